// ==== files.f ====
+incdir+verification
src/mipsPkg.sv
src/controller.sv
src/registerFile.sv
src/executeUnit.sv
src/dataMemory.sv
src/nextPc.sv
src/mipsCore.sv
verification/mipsCoreTb.sv

// ==== src/controller.sv ====
module controller import mipsPkg::*; (
    input  instrT instr,
    output ctrlT  ctrl
);

    logic isR;
    logic isAdd, isSub, isXor, isSll, isJr, isJalr;
    logic isOri, isAddi, isLui, isLw, isLb, isSw;
    logic isBeq, isBgtz, isJ, isJal;

    // one-hot instruction flags.
    assign isR    = instr.r.opcode == opRtype;
    assign isAdd  = isR && instr.r.funct == fnAdd;
    assign isSub  = isR && instr.r.funct == fnSub;
    assign isXor  = isR && instr.r.funct == fnXor;
    assign isSll  = isR && instr.r.funct == fnSll;
    assign isJr   = isR && instr.r.funct == fnJr;
    assign isJalr = isR && instr.r.funct == fnJalr;
    assign isOri  = instr.i.opcode == opOri;
    assign isAddi = instr.i.opcode == opAddi;
    assign isLui  = instr.i.opcode == opLui;
    assign isLw   = instr.i.opcode == opLw;
    assign isLb   = instr.i.opcode == opLb;
    assign isSw   = instr.i.opcode == opSw;
    assign isBeq  = instr.i.opcode == opBeq;
    assign isBgtz = instr.i.opcode == opBgtz;
    assign isJ    = instr.j.opcode == opJ;
    assign isJal  = instr.j.opcode == opJal;

    always_comb begin
        // unknown encodings fall through as a no-op.
        ctrl = '{aluOp: aluAdd, extOp: extZero, aluSrc: 1'b0, memWrite: 1'b0,
                 regWrite: 1'b0, wbSel: wbAlu, regAddr: 5'd0, npcSel: npcSeq,
                 isBeq: 1'b0, isBgtz: 1'b0};

        if (isSub) begin
            ctrl.aluOp = aluSub;
        end else if (isXor) begin
            ctrl.aluOp = aluXor;
        end else if (isOri) begin
            ctrl.aluOp = aluOr;
        end else if (isSll) begin
            ctrl.aluOp = aluSll;
        end

        if (isAddi || isLw || isLb || isSw || isBeq || isBgtz) begin
            ctrl.extOp = extSign;
        end else if (isLui) begin
            ctrl.extOp = extUpper;
        end

        ctrl.aluSrc   = isOri | isAddi | isLui | isLw | isLb | isSw;
        ctrl.memWrite = isSw;
        ctrl.regWrite = isAdd | isSub | isXor | isSll | isJalr | isOri | isAddi |
                        isLui | isLw | isLb | isJal;

        if (isLw) begin
            ctrl.wbSel = wbWord;
        end else if (isLb) begin
            ctrl.wbSel = wbByte;
        end else if (isJal || isJalr) begin
            ctrl.wbSel = wbLink;
        end

        // destination is rd, rt or the link register.
        if (isAdd || isSub || isXor || isSll || isJalr) begin
            ctrl.regAddr = instr.r.rd;
        end else if (isOri || isAddi || isLui || isLw || isLb) begin
            ctrl.regAddr = instr.i.rt;
        end else if (isJal) begin
            ctrl.regAddr = 5'd31;
        end

        if (isBeq || isBgtz) begin
            ctrl.npcSel = npcBranch;
        end else if (isJ || isJal) begin
            ctrl.npcSel = npcJump;
        end else if (isJr || isJalr) begin
            ctrl.npcSel = npcReg;
        end

        ctrl.isBeq  = isBeq;
        ctrl.isBgtz = isBgtz;
    end

endmodule

// ==== src/dataMemory.sv ====
module dataMemory #(
    parameter int memWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] wordData,
    output logic [31:0] byteData
);

    localparam int idxBits = $clog2(memWords);

    logic [31:0]        mem [memWords];
    logic [idxBits-1:0] idx;
    logic [7:0]         byteSel;

    assign idx = addr[2 +: idxBits];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < memWords; k++) begin
                mem[k] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign wordData = mem[idx];

    // little-endian byte lane.
    assign byteSel  = wordData[8 * addr[1:0] +: 8];
    assign byteData = {{24{byteSel[7]}}, byteSel};

endmodule

// ==== src/executeUnit.sv ====
module executeUnit import mipsPkg::*; (
    input  ctrlT        ctrl,
    input  instrT       instr,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    output logic [31:0] aluResult,
    output logic        equal,
    output logic        positive
);

    logic [31:0] extImm;
    logic [31:0] srcA;
    logic [31:0] srcB;

    always_comb begin
        case (ctrl.extOp)
            extSign:  extImm = {{16{instr.i.imm16[15]}}, instr.i.imm16};
            extUpper: extImm = {instr.i.imm16, 16'h0000};
            default:  extImm = {16'h0000, instr.i.imm16};
        endcase
    end

    // lui ignores rs.
    assign srcA = (ctrl.extOp == extUpper) ? 32'd0 : rsData;
    assign srcB = ctrl.aluSrc ? extImm : rtData;

    always_comb begin
        case (ctrl.aluOp)
            aluSub:  aluResult = srcA - srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSll:  aluResult = srcB << instr.r.shamt;
            default: aluResult = srcA + srcB;
        endcase
    end

    // branch compare flags.
    assign equal    = rsData == rtData;
    assign positive = $signed(rsData) > 0;

endmodule

// ==== src/mipsCore.sv ====
module mipsCore import mipsPkg::*; #(
    parameter int memWords = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  instrT       instr,
    input  logic        instrValid,
    output logic        instrReady,
    output logic [31:0] pc,
    output retireT      retire,
    output logic        retireValid,
    input  logic        retireReady
);

    ctrlT        ctrl;
    logic        fire;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        equal;
    logic        positive;
    logic [31:0] wordData;
    logic [31:0] byteData;
    logic [31:0] pcNext;
    logic [31:0] wbData;

    // both streams move together.
    assign instrReady  = retireReady;
    assign retireValid = instrValid;
    assign fire        = instrValid & retireReady;

    controller uController (
        .instr (instr),
        .ctrl  (ctrl)
    );

    registerFile uRegisterFile (
        .clk    (clk),
        .reset  (reset),
        .rs     (instr.r.rs),
        .rt     (instr.r.rt),
        .we     (fire & ctrl.regWrite),
        .wa     (ctrl.regAddr),
        .wd     (wbData),
        .rsData (rsData),
        .rtData (rtData)
    );

    executeUnit uExecuteUnit (
        .ctrl      (ctrl),
        .instr     (instr),
        .rsData    (rsData),
        .rtData    (rtData),
        .aluResult (aluResult),
        .equal     (equal),
        .positive  (positive)
    );

    dataMemory #(
        .memWords (memWords)
    ) uDataMemory (
        .clk      (clk),
        .reset    (reset),
        .we       (fire & ctrl.memWrite),
        .addr     (aluResult),
        .wdata    (rtData),
        .wordData (wordData),
        .byteData (byteData)
    );

    nextPc uNextPc (
        .clk      (clk),
        .reset    (reset),
        .advance  (fire),
        .ctrl     (ctrl),
        .instr    (instr),
        .rsData   (rsData),
        .equal    (equal),
        .positive (positive),
        .pc       (pc),
        .pcNext   (pcNext)
    );

    always_comb begin
        case (ctrl.wbSel)
            wbWord:  wbData = wordData;
            wbLink:  wbData = pc + 32'd4;
            wbByte:  wbData = byteData;
            default: wbData = aluResult;
        endcase
    end

    // report of the instruction on offer this cycle.
    assign retire = '{pc: pc, regWrite: ctrl.regWrite, regAddr: ctrl.regAddr,
                      regData: wbData, memWrite: ctrl.memWrite, memAddr: aluResult,
                      memData: rtData, nextPc: pcNext};

endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

    // primary opcodes, R-type shares zero.
    typedef enum logic [5:0] {
        opRtype = 6'b000000,
        opJ     = 6'b000010,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opBgtz  = 6'b000111,
        opAddi  = 6'b001000,
        opOri   = 6'b001101,
        opLui   = 6'b001111,
        opLb    = 6'b100000,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnXor  = 6'b100110
    } functT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluOr, aluSll} aluOpT;
    typedef enum logic [1:0] {extZero, extSign, extUpper} extOpT;
    typedef enum logic [1:0] {wbAlu, wbWord, wbLink, wbByte} wbSelT;
    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcReg} npcSelT;

    // one word, three formats.
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] imm26;
        } j;
    } instrT;

    typedef struct packed {
        aluOpT      aluOp;
        extOpT      extOp;
        logic       aluSrc;
        logic       memWrite;
        logic       regWrite;
        wbSelT      wbSel;
        logic [4:0] regAddr;
        npcSelT     npcSel;
        logic       isBeq;
        logic       isBgtz;
    } ctrlT;

    typedef struct packed {
        logic [31:0] pc;
        logic        regWrite;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [31:0] memData;
        logic [31:0] nextPc;
    } retireT;

    localparam logic [31:0] resetPc = 32'h0000_3000;

endpackage

// ==== src/nextPc.sv ====
module nextPc import mipsPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    input  ctrlT        ctrl,
    input  instrT       instr,
    input  logic [31:0] rsData,
    input  logic        equal,
    input  logic        positive,
    output logic [31:0] pc,
    output logic [31:0] pcNext
);

    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic        taken;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
    assign taken        = (ctrl.isBeq & equal) | (ctrl.isBgtz & positive);

    always_comb begin
        case (ctrl.npcSel)
            npcBranch: pcNext = taken ? pcPlus4 + branchOffset : pcPlus4;
            npcJump:   pcNext = {pcPlus4[31:28], instr.j.imm26, 2'b00};
            npcReg:    pcNext = rsData;
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (advance) begin
            pc <= pcNext;
        end
    end

endmodule

// ==== src/registerFile.sv ====
module registerFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    // $0 is cleared by reset and never written.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // no forwarding, single-cycle core.
    assign rsData = regs[rs];
    assign rtData = regs[rt];

endmodule

// ==== verification/coreModel.svh ====
`ifndef coreModelSvh
`define coreModelSvh

// architectural state of the reference model.
logic [31:0] modelRegs [32];
logic [31:0] modelMem [memWords];
logic [31:0] modelPc;

// expected retire record for a word offered at modelPc.
task automatic predict(input logic [31:0] w, output retireT e);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] sImm;
    logic [31:0] addr;
    logic [31:0] word;
    logic [7:0]  b;
    logic [31:0] pc4;
    logic [31:0] wd;
    logic [31:0] npc;
    op    = w[31:26];
    fn    = w[5:0];
    rsVal = modelRegs[w[25:21]];
    rtVal = modelRegs[w[20:16]];
    sImm  = {{16{w[15]}}, w[15:0]};
    addr  = rsVal + sImm;
    word  = modelMem[addr[2 +: idxBits]];
    b     = word[8 * addr[1:0] +: 8];
    pc4   = modelPc + 32'd4;
    wd    = '0;
    npc   = pc4;
    case (op)
        6'h00: begin
            case (fn)
                6'h20: wd = rsVal + rtVal;
                6'h22: wd = rsVal - rtVal;
                6'h26: wd = rsVal ^ rtVal;
                6'h00: wd = rtVal << w[10:6];
                6'h09: wd = pc4;
                default: wd = '0;
            endcase
            if (fn == 6'h08 || fn == 6'h09) begin
                npc = rsVal;
            end
        end
        6'h0d: wd = rsVal | {16'h0000, w[15:0]};
        6'h08: wd = rsVal + sImm;
        6'h0f: wd = {w[15:0], 16'h0000};
        6'h23: wd = word;
        6'h20: wd = {{24{b[7]}}, b};
        6'h03: wd = pc4;
        default: wd = '0;
    endcase
    if (op == 6'h02 || op == 6'h03) begin
        npc = {pc4[31:28], w[25:0], 2'b00};
    end
    if ((op == 6'h04 && rsVal == rtVal) || (op == 6'h07 && $signed(rsVal) > 0)) begin
        npc = pc4 + {sImm[29:0], 2'b00};
    end
    e          = '0;
    e.pc       = modelPc;
    e.regWrite = (op == 6'h00 && (fn == 6'h20 || fn == 6'h22 || fn == 6'h26 ||
                  fn == 6'h00 || fn == 6'h09)) || op == 6'h0d || op == 6'h08 ||
                 op == 6'h0f || op == 6'h23 || op == 6'h20 || op == 6'h03;
    e.regAddr  = (op == 6'h00) ? w[15:11] : (op == 6'h03) ? 5'd31 : w[20:16];
    e.regData  = wd;
    e.memWrite = op == 6'h2b;
    e.memAddr  = addr;
    e.memData  = rtVal;
    e.nextPc   = npc;
endtask

// state update at a fire.
task automatic commit(input retireT e);
    if (e.regWrite && e.regAddr != 5'd0) begin
        modelRegs[e.regAddr] = e.regData;
    end
    if (e.memWrite) begin
        modelMem[e.memAddr[2 +: idxBits]] = e.memData;
    end
    modelPc = e.nextPc;
endtask

`endif

// ==== verification/mipsCoreTb.sv ====
module mipsCoreTb import mipsPkg::*; ;

    localparam int memWords = 256;
    localparam int idxBits = $clog2(memWords);
    localparam int clkPeriod = 4;
    localparam int runCycles = 3000;
    localparam int resetCycles = 10;
    localparam logic [31:0] bootPc = 32'h0000_3000;

    logic        clk;
    logic        reset;
    instrT       instr;
    logic        instrValid;
    logic        instrReady;
    logic [31:0] pc;
    retireT      retire;
    logic        retireValid;
    logic        retireReady;
    integer      seed;
    logic [31:0] word;
    retireT      expected;

    `include "coreModel.svh"

    mipsCore #(
        .memWords (memWords)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .pc          (pc),
        .retire      (retire),
        .retireValid (retireValid),
        .retireReady (retireReady)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(2 * runCycles * clkPeriod);
        $display("Watchdog expired: the test loop did not finish in time.");
        $display("Test failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] want);
        if (actual !== want) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // {opcode, funct} per kind and field limits for loads and stores.
    task automatic randomInstr(output logic [31:0] w);
        logic [3:0]  kind;
        logic [11:0] enc;
        kind = $random(seed);
        w = $random(seed);
        case (kind)
            4'd0:  enc = 12'h020;
            4'd1:  enc = 12'h022;
            4'd2:  enc = 12'h026;
            4'd3:  enc = 12'h000;
            4'd4:  enc = 12'h008;
            4'd5:  enc = 12'h009;
            4'd6:  enc = 12'h340;
            4'd7:  enc = 12'h200;
            4'd8:  enc = 12'h3c0;
            4'd9:  enc = 12'h8c0;
            4'd10: enc = 12'h800;
            4'd11: enc = 12'hac0;
            4'd12: enc = 12'h100;
            4'd13: enc = 12'h1c0;
            4'd14: enc = 12'h080;
            default: enc = 12'h0c0;
        endcase
        w[31:26] = enc[11:6];
        if (kind < 4'd6) begin
            w[5:0] = enc[5:0];
        end
        // base $0 and an offset below 64 bytes.
        if (kind >= 4'd9 && kind <= 4'd11) begin
            w[25:21] = 5'd0;
            w[15:6]  = '0;
        end
        if (kind == 4'd13) begin
            w[20:16] = 5'd0;
        end
    endtask

    task automatic compareRetire(input retireT e);
        check("retire.pc", retire.pc, e.pc);
        check("retire.regWrite", retire.regWrite, e.regWrite);
        if (e.regWrite) begin
            check("retire.regAddr", retire.regAddr, e.regAddr);
            check("retire.regData", retire.regData, e.regData);
        end
        check("retire.memWrite", retire.memWrite, e.memWrite);
        if (e.memWrite) begin
            check("retire.memAddr", retire.memAddr, e.memAddr);
            check("retire.memData", retire.memData, e.memData);
        end
        check("retire.nextPc", retire.nextPc, e.nextPc);
    endtask

    initial begin
        seed        = 32'h0822_b27d;
        reset       = 1'b1;
        instr       = '0;
        instrValid  = 1'b0;
        retireReady = 1'b0;
        modelPc     = bootPc;
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = '0;
        end
        for (int k = 0; k < memWords; k++) begin
            modelMem[k] = '0;
        end
        for (int cycle = 0; cycle < runCycles; cycle++) begin
            @(posedge clk);
            #1;
            reset = (cycle + 1) < resetCycles;
            randomInstr(word);
            instr       = word;
            instrValid  = ($random(seed) & 3) != 0;
            retireReady = ($random(seed) & 3) != 0;
            // combinational outputs settle within the cycle.
            #1;
            check("retireValid", retireValid, instrValid);
            check("instrReady", instrReady, retireReady);
            if (reset) begin
                check("pc", pc, bootPc);
            end else begin
                check("pc", pc, modelPc);
                if (instrValid) begin
                    predict(word, expected);
                    compareRetire(expected);
                    if (retireReady) begin
                        commit(expected);
                    end
                end
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule
